// File: source/spu_pkg.sv
`default_nettype none

package spu_pkg;

    // ----------------------------------------
    //  sizes
    // ----------------------------------------
    localparam int data_bits     = 16;                  // register and data path width
    localparam int reg_count     = 8;                   // number of registers
    localparam int reg_addr_bits = $clog2(reg_count);
    localparam int op_latency    = 2;                   // stages in every op unit

    typedef logic [data_bits-1:0]     spu_data_t;
    typedef logic [reg_addr_bits-1:0] spu_reg_t;

    localparam spu_data_t clear_data = '1;              // written by op_clr

    // ----------------------------------------
    //  instruction set
    // ----------------------------------------
    typedef enum logic [2:0] {
        op_and  = 3'd0,
        op_or   = 3'd1,
        op_xor  = 3'd2,
        op_xnor = 3'd3,
        op_add  = 3'd4,
        op_sub  = 3'd5,
        op_clr  = 3'd6
    } spu_opcode_t;

    typedef struct packed {
        spu_opcode_t opcode;
        spu_reg_t    dst;                               // destination register
        spu_reg_t    src0;
        spu_reg_t    src1;                              // ignored when use_imm set
        logic        use_imm;
        spu_data_t   imm;                               // second operand if use_imm
    } spu_instr_t;

    // ----------------------------------------
    //  result port
    // ----------------------------------------
    typedef struct packed {
        spu_reg_t  dst;
        spu_data_t data;
    } spu_result_t;

endpackage

`default_nettype wire

// File: source/spu_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module spu_regfile
    import spu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  spu_reg_t  rd_addr0,
    input  spu_reg_t  rd_addr1,
    output spu_data_t rd_data0,
    output spu_data_t rd_data1,

    input  logic      wr_en,
    input  spu_reg_t  wr_addr,
    input  spu_data_t wr_data
);

    spu_data_t regs [reg_count];

    // ----------------------------------------
    //  write port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;                          // all registers start at zero
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // ----------------------------------------
    //  read ports, no delay
    // ----------------------------------------
    assign rd_data0 = regs[rd_addr0];
    assign rd_data1 = regs[rd_addr1];

endmodule

`default_nettype wire

// File: source/spu_op_logic.sv
`timescale 1ns/1ns
`default_nettype none

module spu_op_logic
    import spu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cke,

    input  spu_opcode_t opcode,
    input  spu_data_t   operand0,
    input  spu_data_t   operand1,
    input  logic        in_valid,

    output spu_data_t   out_data,
    output logic        out_valid
);

    spu_data_t               calc_data;
    spu_data_t               stage_data [op_latency];
    logic [op_latency-1:0]   stage_valid;

    // ----------------------------------------
    //  first stage operation
    // ----------------------------------------
    always_comb begin
        case (opcode)
            op_and:  calc_data = operand0 & operand1;
            op_or:   calc_data = operand0 | operand1;
            op_xor:  calc_data = operand0 ^ operand1;
            op_xnor: calc_data = ~(operand0 ^ operand1);
            default: calc_data = clear_data;            // op_clr
        endcase
    end

    // ----------------------------------------
    //  pipeline
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (cke) begin
            stage_valid[0] <= in_valid;
            for (int i = 1; i < op_latency; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    // data only moves with its valid, otherwise held
    always_ff @(posedge clk) begin
        if (cke) begin
            if (in_valid) begin
                stage_data[0] <= calc_data;
            end
            for (int i = 1; i < op_latency; i++) begin
                if (stage_valid[i-1]) begin
                    stage_data[i] <= stage_data[i-1];
                end
            end
        end
    end

    assign out_data  = stage_data[op_latency-1];
    assign out_valid = stage_valid[op_latency-1];

endmodule

`default_nettype wire

// File: source/spu_op_arith.sv
`timescale 1ns/1ns
`default_nettype none

module spu_op_arith
    import spu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      cke,

    input  logic      subtract,                         // 1: operand0 - operand1
    input  logic      in_valid,
    input  spu_data_t operand0,
    input  spu_data_t operand1,

    output spu_data_t out_data,
    output logic      out_valid
);

    spu_data_t             calc_data;
    spu_data_t             stage_data [op_latency];
    logic [op_latency-1:0] stage_valid;

    // wraps at data width
    assign calc_data = subtract ? operand0 - operand1 : operand0 + operand1;

    // ----------------------------------------
    //  pipeline
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (cke) begin
            stage_valid[0] <= in_valid;
            for (int i = 1; i < op_latency; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            if (in_valid) begin
                stage_data[0] <= calc_data;             // load on new op only
            end
            for (int i = 1; i < op_latency; i++) begin
                if (stage_valid[i-1]) begin
                    stage_data[i] <= stage_data[i-1];
                end
            end
        end
    end

    assign out_data  = stage_data[op_latency-1];
    assign out_valid = stage_valid[op_latency-1];

endmodule

`default_nettype wire

// File: source/spu_core.sv
`timescale 1ns/1ns
`default_nettype none

module spu_core
    import spu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        instr_valid,
    output logic        instr_ready,
    input  spu_instr_t  instr,

    output logic        result_valid,
    input  logic        result_ready,
    output spu_result_t result
);

    logic                  cke;
    logic                  issue;
    logic                  hazard;
    logic                  logic_valid;
    logic                  arith_valid;
    logic                  subtract;
    spu_data_t             rd_data0;
    spu_data_t             rd_data1;
    spu_data_t             operand1;
    spu_data_t             logic_out_data;
    spu_data_t             arith_out_data;
    logic                  logic_out_valid;
    logic                  arith_out_valid;
    spu_reg_t              dst_pipe [op_latency];
    logic [op_latency-1:0] busy_pipe;                   // stage holds an instruction

    // ----------------------------------------
    //  stall and interlock
    // ----------------------------------------
    assign cke = !result_valid || result_ready;         // freeze while output blocked

    // no forwarding, so wait for any in-flight writer of a source
    always_comb begin
        hazard = 1'b0;
        for (int i = 0; i < op_latency; i++) begin
            if (busy_pipe[i] && (dst_pipe[i] == instr.src0 ||
                    (!instr.use_imm && dst_pipe[i] == instr.src1))) begin
                hazard = 1'b1;
            end
        end
    end

    assign instr_ready = cke && !hazard;
    assign issue       = instr_valid && instr_ready;

    // ----------------------------------------
    //  decode and operands
    // ----------------------------------------
    always_comb begin
        logic_valid = 1'b0;
        arith_valid = 1'b0;
        case (instr.opcode)
            op_add, op_sub: arith_valid = issue;
            default:        logic_valid = issue;        // bitwise ops and clear
        endcase
    end

    assign subtract = (instr.opcode == op_sub);
    assign operand1 = instr.use_imm ? instr.imm : rd_data1;

    spu_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rd_addr0 (instr.src0),
        .rd_addr1 (instr.src1),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1),
        .wr_en    (result_valid && result_ready),      // write back on transfer
        .wr_addr  (result.dst),
        .wr_data  (result.data)
    );

    spu_op_logic u_op_logic (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .opcode    (instr.opcode),
        .operand0  (rd_data0),
        .operand1  (operand1),
        .in_valid  (logic_valid),
        .out_data  (logic_out_data),
        .out_valid (logic_out_valid)
    );

    spu_op_arith u_op_arith (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .subtract  (subtract),
        .in_valid  (arith_valid),
        .operand0  (rd_data0),
        .operand1  (operand1),
        .out_data  (arith_out_data),
        .out_valid (arith_out_valid)
    );

    // ----------------------------------------
    //  destination pipeline
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_pipe <= '0;
        end else if (cke) begin
            busy_pipe[0] <= issue;
            for (int i = 1; i < op_latency; i++) begin
                busy_pipe[i] <= busy_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            if (issue) begin
                dst_pipe[0] <= instr.dst;
            end
            for (int i = 1; i < op_latency; i++) begin
                if (busy_pipe[i-1]) begin
                    dst_pipe[i] <= dst_pipe[i-1];       // step with the units
                end
            end
        end
    end

    // ----------------------------------------
    //  result select
    // ----------------------------------------
    assign result_valid = logic_out_valid || arith_out_valid;
    assign result.dst   = dst_pipe[op_latency-1];
    assign result.data  = arith_out_valid ? arith_out_data : logic_out_data;

endmodule

`default_nettype wire

// File: verif/spu_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module spu_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                          // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);                      // held for 4 cycles
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verif/tb_spu_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_spu_core
    import spu_pkg::*;
;

    localparam int n_entries = 30;

    typedef struct packed {
        spu_instr_t instr;
        spu_data_t  exp_data;                           // from the reference model
    } tb_entry_t;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic        instr_ready;
    spu_instr_t  instr;
    logic        result_valid;
    logic        result_ready;
    spu_result_t result;

    tb_entry_t   entry_table [n_entries];
    spu_data_t   model_regs [reg_count];
    int          n_built;
    int          rx_count;
    logic [31:0] lfsr_state;

    spu_clock_gen u_clock_gen (.clk(clk), .reset(reset));

    spu_core dut (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    // ----------------------------------------
    //  reference model and table
    // ----------------------------------------
    function automatic spu_data_t ref_result(input spu_opcode_t op, input spu_data_t a,
                                             input spu_data_t b);
        logic [data_bits:0] wide;
        wide = '0;
        case (op)
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_xnor: return ~(a ^ b);
            op_add: begin
                wide = {1'b0, a} + {1'b0, b};
                return wide[data_bits-1:0];             // carry dropped
            end
            op_sub: begin
                wide = {1'b0, a} + {1'b0, ~b} + 1'b1;   // two's complement
                return wide[data_bits-1:0];
            end
            default: return {data_bits{1'b1}};          // clear
        endcase
    endfunction

    task automatic add_entry(input spu_opcode_t op, input int dst, input int src0,
                             input int src1, input logic use_imm, input spu_data_t imm);
        tb_entry_t e;
        spu_data_t b;
        b = use_imm ? imm : model_regs[src1];
        e.instr.opcode  = op;
        e.instr.dst     = spu_reg_t'(dst);
        e.instr.src0    = spu_reg_t'(src0);
        e.instr.src1    = spu_reg_t'(src1);
        e.instr.use_imm = use_imm;
        e.instr.imm     = imm;
        e.exp_data      = ref_result(op, model_regs[src0], b);
        model_regs[dst] = e.exp_data;                   // sequential register state
        entry_table[n_built] = e;
        n_built++;
    endtask

    task automatic build_table();
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        n_built = 0;
        add_entry(op_clr,  1, 0, 0, 1'b0, 16'h0000);
        add_entry(op_or,   2, 0, 1, 1'b1, 16'ha5c3);    // src1 holds all ones, ignored
        add_entry(op_xor,  3, 1, 1, 1'b1, 16'h0ff0);
        add_entry(op_and,  4, 2, 1, 1'b0, 16'h0000);
        add_entry(op_and,  4, 0, 1, 1'b0, 16'h0000);
        add_entry(op_or,   5, 2, 3, 1'b0, 16'h0000);
        add_entry(op_xor,  5, 2, 3, 1'b0, 16'h0000);
        add_entry(op_xnor, 6, 2, 3, 1'b0, 16'h0000);
        add_entry(op_xnor, 6, 0, 0, 1'b0, 16'h0000);
        add_entry(op_xnor, 7, 1, 0, 1'b0, 16'h0000);
        add_entry(op_and,  7, 1, 2, 1'b1, 16'h3c3c);
        add_entry(op_sub,  7, 0, 1, 1'b1, 16'h0001);    // 0 - 1
        add_entry(op_add,  6, 1, 0, 1'b1, 16'h0001);    // all ones + 1
        add_entry(op_add,  4, 1, 1, 1'b0, 16'h0000);
        add_entry(op_sub,  3, 0, 1, 1'b0, 16'h0000);
        add_entry(op_add,  2, 2, 5, 1'b0, 16'h0000);
        add_entry(op_sub,  5, 2, 7, 1'b1, 16'h1234);
        add_entry(op_clr,  0, 3, 4, 1'b0, 16'h0000);
        add_entry(op_add,  7, 0, 0, 1'b0, 16'h0000);    // reads the cleared register
        add_entry(op_xor,  6, 0, 2, 1'b0, 16'h0000);
        // dependent chain, each waits on the one before
        add_entry(op_add,  5, 5, 5, 1'b1, 16'h0003);
        add_entry(op_add,  5, 5, 5, 1'b1, 16'h0003);
        add_entry(op_sub,  5, 5, 2, 1'b0, 16'h0000);
        add_entry(op_xnor, 4, 5, 5, 1'b1, 16'h00ff);
        add_entry(op_and,  3, 4, 5, 1'b0, 16'h0000);
        // independent, two in flight
        add_entry(op_or,   1, 6, 7, 1'b1, 16'h8001);
        add_entry(op_add,  2, 6, 7, 1'b0, 16'h0000);
        add_entry(op_sub,  0, 7, 6, 1'b0, 16'h0000);
        add_entry(op_xor,  6, 1, 2, 1'b0, 16'h0000);
        add_entry(op_clr,  7, 3, 3, 1'b0, 16'h0000);
    endtask

    // ----------------------------------------
    //  helpers
    // ----------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic take_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        return b;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic issue_instr(input spu_instr_t ins);
        instr_valid <= 1'b1;
        instr       <= ins;
        @(negedge clk);
        while (!instr_ready) begin
            @(negedge clk);                             // stalled or interlocked
        end
        @(posedge clk);                                 // transfer edge
    endtask

    // ----------------------------------------
    //  processes
    // ----------------------------------------
    initial begin
        lfsr_state   = 32'h437e_5f96;
        result_ready = 1'b0;
        forever begin
            @(posedge clk);
            result_ready <= reset ? 1'b0 : (take_bit() | take_bit());   // about 3/4 ready
        end
    end

    initial begin
        rx_count = 0;
        forever begin
            @(negedge clk);
            if (!reset && result_valid && result_ready) begin
                if (rx_count >= n_entries) begin
                    $display("got a result with no instruction left to match it");
                    $display("TB FAILED");
                    $fatal(1, "extra result");
                end else begin
                    compare_value("result.dst", 32'(result.dst),
                                  32'(entry_table[rx_count].instr.dst));
                    compare_value("result.data", 32'(result.data),
                                  32'(entry_table[rx_count].exp_data));
                    rx_count++;
                end
            end
        end
    end

    initial begin
        repeat (n_entries * 20) @(posedge clk);
        $display("watchdog expired, the run hung before all results arrived");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        instr_valid = 1'b0;
        instr       = '0;
        build_table();
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        for (int i = 0; i < n_entries; i++) begin
            issue_instr(entry_table[i].instr);
        end
        instr_valid <= 1'b0;
        wait (rx_count == n_entries);
        repeat (10) @(posedge clk);                     // catch duplicates
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
source/spu_pkg.sv
source/spu_regfile.sv
source/spu_op_logic.sv
source/spu_op_arith.sv
source/spu_core.sv
verif/spu_clock_gen.sv
verif/tb_spu_core.sv

// File: Bender.yml
package:
  name: spu_core

dependencies: {}

sources:
  # RTL, in compile order
  - files:
      - source/spu_pkg.sv
      - source/spu_regfile.sv
      - source/spu_op_logic.sv
      - source/spu_op_arith.sv
      - source/spu_core.sv
  # testbench
  - target: test
    files:
      - verif/spu_clock_gen.sv
      - verif/tb_spu_core.sv
